/* rtl/dram_pkg.sv */
// Shared sizes, timing and bus types for the DRAM simulation model.
// Every RTL module and the testbench take their widths, latencies
// and Wishbone structs from here.

package dram_pkg;

    //////////////////////////////////////////////////
    // Sizes and address map
    //////////////////////////////////////////////////

    localparam int DATA_W  = 64;
    localparam int SEL_W   = DATA_W / 8;
    localparam int ADDR_W  = 12;

    // Word address is {row, bank, col}
    localparam int COL_W   = 4;
    localparam int BANK_W  = 2;
    localparam int ROW_W   = 6;
    localparam int N_BANKS = 2 ** BANK_W;

    localparam int N_PORTS = 2;
    localparam int PORT_W  = $clog2(N_PORTS);

    //////////////////////////////////////////////////
    // Timing in clock cycles
    //////////////////////////////////////////////////

    localparam int T_CL  = 2;
    localparam int T_RCD = 3;
    localparam int T_RP  = 3;

    // Wide enough for the longest sequence, precharge + activate + column
    localparam int CNT_W = $clog2(T_RP + T_RCD + T_CL + 1);

    // Wishbone classic master request
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        hit,
        empty,
        conflict
    } access_kind_t;

    // Cycles the bank timer counts for each kind of access
    function automatic int unsigned access_latency(access_kind_t kind);
        case (kind)
            hit:     return T_CL;
            empty:   return T_RCD + T_CL;
            default: return T_RP + T_RCD + T_CL;
        endcase
    endfunction

endpackage

/* rtl/wb_port_arbiter.sv */
// Round-robin arbiter between the Wishbone master ports.
// A grant is held for a whole bus cycle (while the granted cyc is high)
// and the controller response is steered back to the granted port only.

module wb_port_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  dram_pkg::wb_req_t port_req [dram_pkg::N_PORTS],
    output dram_pkg::wb_rsp_t port_rsp [dram_pkg::N_PORTS],
    output dram_pkg::wb_req_t mem_req,
    input  dram_pkg::wb_rsp_t mem_rsp
);
    import dram_pkg::*;

    logic [N_PORTS-1:0] req_vec;
    logic [N_PORTS-1:0] pick_vec;
    logic [PORT_W-1:0]  pick_idx;
    logic               pick_valid;
    logic [N_PORTS-1:0] grant_q;
    logic [PORT_W-1:0]  last_q;
    logic               granted_cyc;
    logic [N_PORTS-1:0] ack_vec;

    //////////////////////////////////////////////////
    // Request selection
    //////////////////////////////////////////////////

    // Scan from the port after the last served one; nearest requester wins
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = '0;
        pick_vec   = '0;
        for (int i = 0; i < N_PORTS; i++) begin
            req_vec[i] = port_req[i].cyc && port_req[i].stb;
        end
        for (int k = N_PORTS; k >= 1; k--) begin
            cand = (int'(last_q) + k) % N_PORTS;
            if (req_vec[cand]) begin
                pick_valid     = 1'b1;
                pick_idx       = PORT_W'(cand);
                pick_vec       = '0;
                pick_vec[cand] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Grant register
    //////////////////////////////////////////////////

    always_comb begin
        granted_cyc = 1'b0;
        for (int i = 0; i < N_PORTS; i++) begin
            granted_cyc = granted_cyc | (grant_q[i] & port_req[i].cyc);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_q <= '0;
            last_q  <= PORT_W'(N_PORTS - 1);
        end else if (grant_q == '0) begin
            if (pick_valid) begin
                grant_q <= pick_vec;
                last_q  <= pick_idx;
            end
        end else if (!granted_cyc) begin
            // Cycle ended, arbitrate again next cycle
            grant_q <= '0;
        end
    end

    // Forward the granted request, idle bus otherwise
    always_comb begin
        mem_req = '0;
        for (int i = 0; i < N_PORTS; i++) begin
            if (grant_q[i]) begin
                mem_req = port_req[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N_PORTS; i++) begin
            ack_vec[i]      = grant_q[i] & mem_rsp.ack;
            port_rsp[i].ack = ack_vec[i];
            port_rsp[i].dat = grant_q[i] ? mem_rsp.dat : '0;
        end
    end

    a_single_ack : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ack_vec))
        else $error("ack seen on more than one port");

endmodule

/* rtl/dram_bank_timer.sv */
// Open-page bank state and access latency counter.
// On start the access is sorted as hit, empty bank or row conflict,
// the bank's open row is updated, and a down-counter runs out the
// matching latency; done is high in the counter's last cycle.

module dram_bank_timer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [dram_pkg::BANK_W-1:0]  bank,
    input  logic [dram_pkg::ROW_W-1:0]   row,
    output logic                         done,
    output dram_pkg::access_kind_t       kind
);
    import dram_pkg::*;

    // Per-bank open-row state
    logic [N_BANKS-1:0] open_q;
    logic [ROW_W-1:0]   open_row_q [N_BANKS];

    logic [CNT_W-1:0]   cnt_q;
    logic [CNT_W-1:0]   load_val;
    access_kind_t       kind_c;
    access_kind_t       kind_q;

    //////////////////////////////////////////////////
    // Access classification
    //////////////////////////////////////////////////

    always_comb begin
        if (!open_q[bank]) begin
            kind_c = empty;
        end else if (open_row_q[bank] == row) begin
            kind_c = hit;
        end else begin
            kind_c = conflict;
        end
    end

    assign load_val = CNT_W'(access_latency(kind_c));

    //////////////////////////////////////////////////
    // Bank state and latency counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            open_q <= '0;
            cnt_q  <= '0;
            kind_q <= empty;
        end else begin
            if (start) begin
                // Open page policy, the row stays open after the access
                open_q[bank] <= 1'b1;
                cnt_q        <= load_val;
                kind_q       <= kind_c;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Row address of each open bank
    always_ff @(posedge clk) begin
        if (start) begin
            open_row_q[bank] <= row;
        end
    end

    // Last counted cycle, the column data lands one cycle later
    assign done = (cnt_q == CNT_W'(1));
    assign kind = kind_q;

    a_start_idle : assert property (@(posedge clk) disable iff (!rst_n)
        start |-> (cnt_q == '0))
        else $error("bank timer started while still counting");

endmodule

/* rtl/dram_array.sv */
// On-chip storage behind the DRAM model.
// One word per address, byte-lane write enables, and a registered
// read port whose data is valid the cycle after en.

module dram_array (
    input  logic                        clk,
    input  logic                        en,
    input  logic                        we,
    input  logic [dram_pkg::SEL_W-1:0]  sel,
    input  logic [dram_pkg::ADDR_W-1:0] adr,
    input  logic [dram_pkg::DATA_W-1:0] wdat,
    output logic [dram_pkg::DATA_W-1:0] rdat
);
    import dram_pkg::*;

    logic [DATA_W-1:0] mem [2 ** ADDR_W];

    //////////////////////////////////////////////////
    // Write and read port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel[b]) begin
                        mem[adr][8*b +: 8] <= wdat[8*b +: 8];
                    end
                end
            end
            // Old contents on a write cycle
            rdat <= mem[adr];
        end
    end

endmodule

/* rtl/dram_controller.sv */
// DRAM controller FSM behind the port arbiter.
// Takes one Wishbone classic request at a time, asks the bank timer
// for the open-page latency, then accesses the array and acks.
// Latency from an idle bus is T_CL, T_RCD+T_CL or T_RP+T_RCD+T_CL plus two.

module dram_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  dram_pkg::wb_req_t req,
    output dram_pkg::wb_rsp_t rsp
);
    import dram_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait,
        st_resp
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic              start;
    logic              done;
    logic              arr_en;
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    logic [DATA_W-1:0] rdat;
    logic [CNT_W-1:0]  wait_cnt_q;
    access_kind_t      kind;

    // Address split
    assign bank = req.adr[COL_W +: BANK_W];
    assign row  = req.adr[COL_W + BANK_W +: ROW_W];

    //////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:  if (req.cyc && req.stb) state_d = st_issue;
            st_issue: state_d = st_wait;
            st_wait:  if (done) state_d = st_resp;
            default:  state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            wait_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            // Cycles spent waiting on the timer
            if (state_q == st_wait) begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end else begin
                wait_cnt_q <= '0;
            end
        end
    end

    assign start  = (state_q == st_issue);
    assign arr_en = (state_q == st_wait) && done;

    assign rsp.ack = (state_q == st_resp);
    assign rsp.dat = rdat;

    dram_bank_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .bank  (bank),
        .row   (row),
        .done  (done),
        .kind  (kind)
    );

    dram_array u_array (
        .clk  (clk),
        .en   (arr_en),
        .we   (req.we),
        .sel  (req.sel),
        .adr  (req.adr),
        .wdat (req.dat),
        .rdat (rdat)
    );

    a_ack_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        rsp.ack |=> !rsp.ack)
        else $error("ack held for two cycles");

    // Wait time must agree with the timer's classification
    a_wait_len : assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == st_wait && done) |->
            (wait_cnt_q == CNT_W'(access_latency(kind) - 1)))
        else $error("wait length does not match access kind");

endmodule

/* rtl/dram_sim_top.sv */
// Top level of the DRAM simulation model.
// Two Wishbone classic master ports share one controller and array
// through the round-robin arbiter.

module dram_sim_top (
    input  logic              clk,
    input  logic              rst_n,
    input  dram_pkg::wb_req_t port_req [dram_pkg::N_PORTS],
    output dram_pkg::wb_rsp_t port_rsp [dram_pkg::N_PORTS]
);
    import dram_pkg::*;

    // Granted request and its response
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    //////////////////////////////////////////////////
    // Arbitration
    //////////////////////////////////////////////////

    wb_port_arbiter u_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .port_req (port_req),
        .port_rsp (port_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    //////////////////////////////////////////////////
    // Controller with timer and storage
    //////////////////////////////////////////////////

    dram_controller u_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

/* testbench/dram_sim_checker.sv */
// Scoreboard for the DRAM model testbench.
// Samples both Wishbone ports on the rising edge, keeps a shadow memory,
// checks read data, solo-access latency and round-robin order, and
// prints one line per finished access plus a closing count line.

module dram_sim_checker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  dram_pkg::wb_req_t            port_req [dram_pkg::N_PORTS],
    input  dram_pkg::wb_rsp_t            port_rsp [dram_pkg::N_PORTS],
    input  logic [dram_pkg::N_PORTS-1:0] solo,
    input  dram_pkg::access_kind_t       exp_kind [dram_pkg::N_PORTS],
    input  int                           row_tag [dram_pkg::N_PORTS],
    input  logic                         report,
    output int                           test_cnt,
    output int                           fail_cnt,
    output int                           err_cnt
);
    import dram_pkg::*;

    logic [DATA_W-1:0]  shadow [int];
    int                 cyc_cnt;
    logic [N_PORTS-1:0] active;
    logic [N_PORTS-1:0] started;
    logic [N_PORTS-1:0] acks;
    logic [N_PORTS-1:0] solo_q;
    access_kind_t       kind_q [N_PORTS];
    int                 start_cyc [N_PORTS];
    int                 row_q [N_PORTS];
    int                 last_served;
    int                 first_exp;
    logic               contest;
    logic               reported;

    // Top-level latency from the first sampled stb to the rising ack
    function automatic int expected_latency(access_kind_t k);
        case (k)
            hit:     return T_CL + 2;
            empty:   return T_RCD + T_CL + 2;
            default: return T_RP + T_RCD + T_CL + 2;
        endcase
    endfunction

    task automatic check_ack(input int p);
        wb_req_t           r;
        logic [DATA_W-1:0] word;
        int                lat;
        int                lat_exp;
        int                errs;
        string             tag;
        r    = port_req[p];
        errs = 0;
        // ack is sampled one edge after it rises
        lat  = cyc_cnt - start_cyc[p] - 1;
        if (!active[p]) begin
            $display("error %0t: ack on port %0d with no request open", $time, p);
            err_cnt++;
            return;
        end
        if (contest) begin
            if (p != first_exp) begin
                $display("error %0t: row %0d port %0d served first, round robin expects port %0d",
                         $time, row_q[p], p, first_exp);
                errs++;
            end
            contest = 1'b0;
        end
        if (solo_q[p]) begin
            lat_exp = expected_latency(kind_q[p]);
            if (lat != lat_exp) begin
                $display("error %0t: row %0d port %0d latency %0d, expected %0d for %s",
                         $time, row_q[p], p, lat, lat_exp, kind_q[p].name());
                errs++;
            end
        end
        if (r.we) begin
            word = shadow.exists(int'(r.adr)) ? shadow[int'(r.adr)] : '0;
            for (int b = 0; b < SEL_W; b++) begin
                if (r.sel[b]) begin
                    word[8*b +: 8] = r.dat[8*b +: 8];
                end
            end
            shadow[int'(r.adr)] = word;
        end else if (!shadow.exists(int'(r.adr))) begin
            $display("error %0t: row %0d reads 0x%03h, never written", $time, row_q[p], r.adr);
            errs++;
        end else if (port_rsp[p].dat !== shadow[int'(r.adr)]) begin
            $display("error %0t: row %0d port %0d read 0x%h at 0x%03h, expected 0x%h",
                     $time, row_q[p], p, port_rsp[p].dat, r.adr, shadow[int'(r.adr)]);
            errs++;
        end
        tag = solo_q[p] ? kind_q[p].name() : "contested";
        test_cnt++;
        if (errs == 0) begin
            $display("test %0d: row %0d port %0d %s 0x%03h %s latency %0d ok",
                     test_cnt, row_q[p], p, r.we ? "write" : "read", r.adr, tag, lat);
        end else begin
            $display("test %0d: row %0d port %0d failed", test_cnt, row_q[p], p);
            fail_cnt++;
        end
        last_served = p;
        active[p]   = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Sampling on the rising edge
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            cyc_cnt     = 0;
            active      = '0;
            contest     = 1'b0;
            first_exp   = 0;
            last_served = -1;
            test_cnt    = 0;
            fail_cnt    = 0;
            err_cnt     = 0;
            reported    = 1'b0;
            shadow.delete();
        end else begin
            cyc_cnt++;
            started = '0;
            for (int p = 0; p < N_PORTS; p++) begin
                acks[p] = port_rsp[p].ack;
            end
            if ($countones(acks) > 1) begin
                $display("error %0t: ack high on both ports in one cycle", $time);
                err_cnt++;
            end
            for (int p = 0; p < N_PORTS; p++) begin
                if (acks[p]) begin
                    check_ack(p);
                end else if (!active[p] && port_req[p].cyc && port_req[p].stb) begin
                    active[p]    = 1'b1;
                    started[p]   = 1'b1;
                    start_cyc[p] = cyc_cnt;
                    solo_q[p]    = solo[p];
                    kind_q[p]    = exp_kind[p];
                    row_q[p]     = row_tag[p];
                end
            end
            // Both ports raised stb together, the one not served last wins
            if (&started) begin
                contest   = 1'b1;
                first_exp = (last_served + 1) % N_PORTS;
            end
            if (report && !reported) begin
                $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                         test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
                reported = 1'b1;
            end
        end
    end

endmodule

/* testbench/dram_sim_tb.sv */
// Testbench for the two-port DRAM model.
// Builds a table of Wishbone accesses, applies it row by row on the
// falling edge and leaves all comparing to the checker module.

module dram_sim_tb;
    import dram_pkg::*;

    typedef struct packed {
        logic [PORT_W-1:0] port;
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic              conc;
        access_kind_t      kind;
    } row_t;

    logic               clk;
    logic               rst_n;
    wb_req_t            port_req [N_PORTS];
    wb_rsp_t            port_rsp [N_PORTS];
    logic [N_PORTS-1:0] solo;
    access_kind_t       exp_kind [N_PORTS];
    int                 row_tag [N_PORTS];
    logic               report;
    int                 test_cnt;
    int                 fail_cnt;
    int                 err_cnt;
    row_t               tbl [$];
    int                 i;

    dram_sim_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .port_req (port_req),
        .port_rsp (port_rsp)
    );

    dram_sim_checker u_chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .port_req (port_req),
        .port_rsp (port_rsp),
        .solo     (solo),
        .exp_kind (exp_kind),
        .row_tag  (row_tag),
        .report   (report),
        .test_cnt (test_cnt),
        .fail_cnt (fail_cnt),
        .err_cnt  (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Word address is {row, bank, col}
    function automatic logic [dram_pkg::ADDR_W-1:0] make_adr(int row, int bank, int col);
        return {dram_pkg::ROW_W'(row), dram_pkg::BANK_W'(bank), dram_pkg::COL_W'(col)};
    endfunction

    task automatic add_row(input int port, input logic we, input logic [SEL_W-1:0] sel,
                           input logic [ADDR_W-1:0] adr, input logic conc,
                           input access_kind_t kind);
        row_t r;
        r.port = PORT_W'(port);
        r.we   = we;
        r.sel  = sel;
        r.adr  = adr;
        r.dat  = {$urandom, $urandom};
        r.conc = conc;
        r.kind = kind;
        tbl.push_back(r);
    endtask

    task automatic start_req(input int r, input logic is_solo);
        wb_req_t req;
        int      p;
        p        = tbl[r].port;
        req.cyc  = 1'b1;
        req.stb  = 1'b1;
        req.we   = tbl[r].we;
        req.sel  = tbl[r].sel;
        req.adr  = tbl[r].adr;
        req.dat  = tbl[r].dat;
        port_req[p] = req;
        solo[p]     = is_solo;
        exp_kind[p] = tbl[r].kind;
        row_tag[p]  = r;
    endtask

    // Runs one solo row or a concurrent pair when rb is not negative
    task automatic run_step(input int ra, input int rb);
        int                 cycles;
        int                 row_of [N_PORTS];
        logic [N_PORTS-1:0] live;
        logic [N_PORTS-1:0] acked;
        live   = '0;
        acked  = '0;
        cycles = 0;
        start_req(ra, rb < 0);
        live[tbl[ra].port]   = 1'b1;
        row_of[tbl[ra].port] = ra;
        if (rb >= 0) begin
            start_req(rb, 1'b0);
            live[tbl[rb].port]   = 1'b1;
            row_of[tbl[rb].port] = rb;
        end
        while (live != '0) begin
            @(negedge clk);
            cycles++;
            for (int p = 0; p < N_PORTS; p++) begin
                if (acked[p]) begin
                    // Drop cyc and stb in the cycle after ack
                    port_req[p] = '0;
                    live[p]     = 1'b0;
                    acked[p]    = 1'b0;
                end else if (live[p] && port_rsp[p].ack) begin
                    acked[p] = 1'b1;
                end else if (live[p] && cycles >= 50) begin
                    $display("port %0d hung on row %0d, no ack within 50 cycles", p, row_of[p]);
                    $display("Verification failed");
                    $finish;
                end
            end
        end
        @(negedge clk);
    endtask

    initial begin
        rst_n  = 1'b0;
        report = 1'b0;
        solo   = '0;
        for (int p = 0; p < N_PORTS; p++) begin
            port_req[p] = '0;
            exp_kind[p] = hit;
            row_tag[p]  = 0;
        end
        void'($urandom(83041));

        //////////////////////////////////////////////////
        // Stimulus table of port, we, sel, address, concurrent flag and kind
        //////////////////////////////////////////////////

        add_row(0, 1'b1, 8'hff, make_adr(5, 0, 1), 1'b0, empty);
        add_row(0, 1'b0, 8'hff, make_adr(5, 0, 1), 1'b0, hit);
        add_row(0, 1'b1, 8'hff, make_adr(5, 0, 2), 1'b0, hit);
        add_row(1, 1'b0, 8'hff, make_adr(5, 0, 2), 1'b0, hit);
        add_row(0, 1'b1, 8'hff, make_adr(9, 1, 0), 1'b0, empty);
        add_row(0, 1'b0, 8'hff, make_adr(9, 1, 0), 1'b0, hit);
        // Two banks keep their own open rows
        add_row(0, 1'b0, 8'hff, make_adr(5, 0, 1), 1'b0, hit);
        add_row(1, 1'b0, 8'hff, make_adr(9, 1, 0), 1'b0, hit);
        add_row(0, 1'b1, 8'hff, make_adr(12, 0, 3), 1'b0, conflict);
        add_row(0, 1'b0, 8'hff, make_adr(12, 0, 3), 1'b0, hit);
        add_row(1, 1'b0, 8'hff, make_adr(5, 0, 1), 1'b0, conflict);
        // Partial writes over older data
        add_row(1, 1'b1, 8'h0f, make_adr(5, 0, 1), 1'b0, hit);
        add_row(0, 1'b1, 8'ha5, make_adr(5, 0, 1), 1'b0, hit);
        add_row(1, 1'b0, 8'hff, make_adr(5, 0, 1), 1'b0, hit);
        add_row(0, 1'b1, 8'h80, make_adr(9, 1, 0), 1'b0, hit);
        add_row(0, 1'b0, 8'hff, make_adr(9, 1, 0), 1'b0, hit);
        add_row(1, 1'b1, 8'hff, make_adr(3, 2, 7), 1'b0, empty);
        add_row(1, 1'b0, 8'hff, make_adr(3, 2, 7), 1'b0, hit);
        add_row(1, 1'b1, 8'hff, make_adr(7, 3, 0), 1'b0, empty);
        // A solo row before each concurrent pair sets the last served port
        add_row(0, 1'b0, 8'hff, make_adr(3, 2, 7), 1'b0, hit);
        add_row(0, 1'b1, 8'hff, make_adr(7, 3, 0), 1'b1, hit);
        add_row(1, 1'b0, 8'hff, make_adr(3, 2, 7), 1'b0, hit);
        add_row(1, 1'b0, 8'hff, make_adr(7, 3, 0), 1'b0, hit);
        add_row(0, 1'b0, 8'hff, make_adr(7, 3, 0), 1'b1, hit);
        add_row(1, 1'b1, 8'h3c, make_adr(5, 0, 1), 1'b0, hit);
        add_row(0, 1'b0, 8'hff, make_adr(5, 0, 1), 1'b0, hit);
        add_row(0, 1'b1, 8'hff, make_adr(1, 3, 5), 1'b1, hit);
        add_row(1, 1'b1, 8'hff, make_adr(1, 3, 6), 1'b0, hit);
        add_row(1, 1'b0, 8'hff, make_adr(1, 3, 6), 1'b0, hit);
        add_row(0, 1'b0, 8'hff, make_adr(1, 3, 5), 1'b1, hit);
        add_row(1, 1'b0, 8'hff, make_adr(5, 0, 1), 1'b0, hit);

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        // Quiet bus after reset with no requests
        repeat (10) @(negedge clk);

        i = 0;
        while (i < tbl.size()) begin
            if (tbl[i].conc) begin
                run_step(i, i + 1);
                i += 2;
            end else begin
                run_step(i, -1);
                i++;
            end
        end

        repeat (4) @(negedge clk);
        report = 1'b1;
        @(negedge clk);
        report = 1'b0;
        if (err_cnt == 0 && fail_cnt == 0 && test_cnt == tbl.size()) begin
            $display("Verification passed");
        end else begin
            if (test_cnt != tbl.size()) begin
                $display("checker saw %0d acks, table has %0d rows", test_cnt, tbl.size());
            end
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* files.f */
rtl/dram_pkg.sv
rtl/wb_port_arbiter.sv
rtl/dram_bank_timer.sv
rtl/dram_array.sv
rtl/dram_controller.sv
rtl/dram_sim_top.sv
testbench/dram_sim_checker.sv
testbench/dram_sim_tb.sv
